// ==== verilog/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// address and cache geometry
`define FETCH_ADDR_W 32
`define FETCH_IDX_BITS 2
`define FETCH_OFF_BITS 1

// first fetch address out of reset
`define FETCH_RESET_PC 32'h8000_0000

// rv32 major opcodes seen by pre-decode
`define FETCH_OP_JAL 7'b1101111
`define FETCH_OP_JALR 7'b1100111
`define FETCH_OP_BRANCH 7'b1100011
`define FETCH_OP_SYSTEM 7'b1110011
`define FETCH_OP_MISC_MEM 7'b0001111
`define FETCH_OP_ALU_IMM 7'b0010011
`define FETCH_OP_ALU_REG 7'b0110011

// funct3 that turns MISC-MEM into FENCE.I
`define FETCH_OP_FENCEI_F3 3'b001

`endif

// ==== verilog/fetch_pkg.sv ====
`include "fetch_cfg.svh"

package fetch_pkg;

  // byte address and instruction word
  typedef logic [`FETCH_ADDR_W-1:0] addr_t;
  typedef logic [31:0] inst_t;

  // line tag and set index of the instruction cache
  typedef logic [`FETCH_ADDR_W-`FETCH_IDX_BITS-`FETCH_OFF_BITS-3:0] tag_t;
  typedef logic [`FETCH_IDX_BITS-1:0] idx_t;

  // item handed to the backend
  typedef struct packed {
    addr_t pc;
    inst_t inst;
    logic  spec;
  } fetch_out_t;

  // real next pc of a control instruction
  typedef struct packed {
    addr_t next_pc;
    logic  fence;
  } resolve_t;

  // one word of a line refill
  typedef struct packed {
    addr_t addr;
  } refill_req_t;

  typedef struct packed {
    inst_t data;
    logic  err;
  } refill_rsp_t;

  // pre-decode result
  typedef enum logic [2:0] {
    CTRL_NONE,
    CTRL_JUMP,
    CTRL_BRANCH,
    CTRL_SYSTEM,
    CTRL_FENCE
  } ctrl_kind_e;

endpackage

// ==== verilog/fetch_axil_rd.sv ====
`timescale 1ns/1ps

module fetch_axil_rd (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_valid_i,
  input  fetch_pkg::refill_req_t req_i,
  output logic                   req_ready_o,
  output logic                   rsp_valid_o,
  output fetch_pkg::refill_rsp_t rsp_o,
  output fetch_pkg::addr_t       m_araddr_o,
  output logic                   m_arvalid_o,
  input  logic                   m_arready_i,
  input  fetch_pkg::inst_t       m_rdata_i,
  input  logic [1:0]             m_rresp_i,
  input  logic                   m_rvalid_i,
  output logic                   m_rready_o
);

  logic req_take;
  logic ar_done;
  logic r_done;

  // one transaction at a time
  assign req_ready_o = ~m_arvalid_o & ~m_rready_o;
  assign req_take = req_valid_i & req_ready_o;
  assign ar_done = m_arvalid_o & m_arready_i;
  assign r_done = m_rready_o & m_rvalid_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_arvalid_o <= 1'b0;
      m_rready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= r_done;
      if (req_take) begin
        m_arvalid_o <= 1'b1;
      end else if (ar_done) begin
        m_arvalid_o <= 1'b0;
        m_rready_o <= 1'b1;
      end else if (r_done) begin
        m_rready_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_take) begin
      m_araddr_o <= req_i.addr;
    end
    // slverr and decerr both set bit 1
    if (r_done) begin
      rsp_o <= '{data: m_rdata_i, err: m_rresp_i[1]};
    end
  end

  // read data only comes back for the one outstanding read
  a_r_outstanding: assert property (@(posedge clk) disable iff (rst)
    m_rvalid_i |-> m_rready_o);

endmodule

// ==== verilog/fetch_icache.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_icache (
  input  logic                   clk,
  input  logic                   rst,
  input  fetch_pkg::addr_t       lookup_pc_i,
  output logic                   hit_o,
  output fetch_pkg::inst_t       inst_o,
  input  logic                   flush_i,
  output logic                   req_valid_o,
  output fetch_pkg::refill_req_t req_o,
  input  logic                   req_ready_i,
  input  logic                   rsp_valid_i,
  input  fetch_pkg::refill_rsp_t rsp_i
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FILL0,
    ST_FILL1,
    ST_DONE
  } icache_state_e;

  localparam int IDX_BITS = `FETCH_IDX_BITS;
  localparam int OFF_BITS = `FETCH_OFF_BITS;
  localparam int SETS = 1 << IDX_BITS;
  localparam int WORDS = 1 << OFF_BITS;
  localparam int IDX_LSB = OFF_BITS + 2;
  localparam int TAG_LSB = IDX_LSB + IDX_BITS;

  icache_state_e state_q;

  inst_t data_mem [SETS][WORDS];
  tag_t tag_mem [SETS];
  logic [SETS-1:0] valid_q;

  addr_t fill_addr_q;
  logic sent_q;
  logic err_q;
  logic in_fill;

  idx_t look_idx;
  idx_t fill_idx;
  tag_t look_tag;
  tag_t fill_tag;
  logic [OFF_BITS-1:0] look_off;
  logic [OFF_BITS-1:0] fill_word;
  logic look_hit;

  // lookup side
  assign look_idx = lookup_pc_i[TAG_LSB-1:IDX_LSB];
  assign look_tag = lookup_pc_i[`FETCH_ADDR_W-1:TAG_LSB];
  assign look_off = lookup_pc_i[IDX_LSB-1:2];
  assign look_hit = valid_q[look_idx] && (tag_mem[look_idx] == look_tag);

  // no hits while a line is being written
  assign hit_o = (state_q == ST_IDLE) && look_hit;
  assign inst_o = data_mem[look_idx][look_off];

  // refill side
  assign in_fill = (state_q == ST_FILL0) || (state_q == ST_FILL1);
  assign fill_idx = fill_addr_q[TAG_LSB-1:IDX_LSB];
  assign fill_tag = fill_addr_q[`FETCH_ADDR_W-1:TAG_LSB];
  assign fill_word = (state_q == ST_FILL1) ? OFF_BITS'(1) : '0;

  assign req_valid_o = in_fill && !sent_q;
  assign req_o = '{addr: fill_addr_q | addr_t'({fill_word, 2'b00})};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      valid_q <= '0;
      sent_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (!look_hit) begin
            state_q <= ST_FILL0;
            sent_q <= 1'b0;
            err_q <= 1'b0;
          end
        end
        ST_FILL0, ST_FILL1: begin
          if (req_valid_o && req_ready_i) begin
            sent_q <= 1'b1;
          end
          if (rsp_valid_i) begin
            sent_q <= 1'b0;
            err_q <= err_q | rsp_i.err;
            state_q <= (state_q == ST_FILL0) ? ST_FILL1 : ST_DONE;
          end
        end
        ST_DONE: begin
          // a bus error leaves the line invalid, so it is fetched again
          valid_q[fill_idx] <= ~err_q;
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && !look_hit) begin
      fill_addr_q <= {lookup_pc_i[`FETCH_ADDR_W-1:IDX_LSB], IDX_LSB'(0)};
    end
    if (in_fill && rsp_valid_i) begin
      data_mem[fill_idx][fill_word] <= rsp_i.data;
    end
    if (state_q == ST_DONE) begin
      tag_mem[fill_idx] <= fill_tag;
    end
  end

  // a response only answers a request already sent for this fill
  a_rsp_in_fill: assert property (@(posedge clk) disable iff (rst)
    rsp_valid_i |-> (in_fill && sent_q));

endmodule

// ==== verilog/fetch_pc_ctrl.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_pc_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  output fetch_pkg::addr_t      lookup_pc_o,
  input  logic                  hit_i,
  input  fetch_pkg::inst_t      inst_i,
  output logic                  flush_o,
  output logic                  out_valid_o,
  output fetch_pkg::fetch_out_t out_data_o,
  input  logic                  out_ready_i,
  input  logic                  resolve_valid_i,
  input  fetch_pkg::resolve_t   resolve_i,
  output logic                  kill_o
);
  import fetch_pkg::*;

  addr_t pc_q;
  addr_t btb_q;
  addr_t pred_q;
  logic btb_valid_q;
  logic spec_q;
  logic wait_q;
  logic kill_q;
  ctrl_kind_e kind;
  ctrl_kind_e spec_kind_q;
  ctrl_kind_e wait_kind_q;
  ctrl_kind_e res_kind;

  logic handoff;
  logic res_spec;
  logic mispredict;
  logic spec_now;
  logic can_predict;
  logic btb_load;

  // pre-decode of the presented word
  always_comb begin
    kind = CTRL_NONE;
    case (inst_i[6:0])
      `FETCH_OP_JAL, `FETCH_OP_JALR: kind = CTRL_JUMP;
      `FETCH_OP_BRANCH: kind = CTRL_BRANCH;
      `FETCH_OP_SYSTEM: kind = CTRL_SYSTEM;
      `FETCH_OP_MISC_MEM: begin
        if (inst_i[14:12] == `FETCH_OP_FENCEI_F3) begin
          kind = CTRL_FENCE;
        end
      end
      default: kind = CTRL_NONE;
    endcase
  end

  // resolves come in order, the open speculation is always the oldest
  assign res_spec = resolve_valid_i & spec_q;
  assign mispredict = res_spec & (resolve_i.next_pc != pred_q);
  assign spec_now = spec_q & ~res_spec;
  assign res_kind = spec_q ? spec_kind_q : wait_kind_q;
  assign btb_load = resolve_valid_i & ((res_kind == CTRL_JUMP) | (res_kind == CTRL_BRANCH));

  assign lookup_pc_o = pc_q;
  assign out_valid_o = hit_i & ~wait_q & ~mispredict;
  assign out_data_o = '{pc: pc_q, inst: inst_i, spec: spec_now};
  assign handoff = out_valid_o & out_ready_i;

  // only jumps and branches follow the btb
  assign can_predict = btb_valid_q & ~spec_now &
                       ((kind == CTRL_JUMP) | (kind == CTRL_BRANCH));
  assign flush_o = handoff & (kind == CTRL_FENCE);
  assign kill_o = kill_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `FETCH_RESET_PC;
      btb_valid_q <= 1'b0;
      spec_q <= 1'b0;
      wait_q <= 1'b0;
      kill_q <= 1'b0;
    end else begin
      kill_q <= mispredict;
      if (btb_load) begin
        btb_valid_q <= 1'b1;
      end
      if (mispredict) begin
        pc_q <= resolve_i.next_pc;
        spec_q <= 1'b0;
        wait_q <= 1'b0;
      end else if (resolve_valid_i && !spec_q) begin
        // stalled instruction resolved
        pc_q <= resolve_i.next_pc;
        wait_q <= 1'b0;
      end else begin
        if (res_spec) begin
          spec_q <= 1'b0;
        end
        if (handoff) begin
          if (kind == CTRL_NONE) begin
            pc_q <= pc_q + addr_t'(4);
          end else if (can_predict) begin
            pc_q <= btb_q;
            spec_q <= 1'b1;
          end else begin
            wait_q <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (btb_load) begin
      btb_q <= resolve_i.next_pc;
    end
    if (handoff && can_predict) begin
      pred_q <= btb_q;
      spec_kind_q <= kind;
    end
    if (handoff && !can_predict && kind != CTRL_NONE) begin
      wait_kind_q <= kind;
    end
  end

  a_resolve_pending: assert property (@(posedge clk) disable iff (rst)
    resolve_valid_i |-> (spec_q || wait_q));

  a_fence_resolve: assert property (@(posedge clk) disable iff (rst)
    resolve_valid_i |-> (resolve_i.fence == (res_kind == CTRL_FENCE)));

  // spec may drop when the open prediction resolves
  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && !out_ready_i && !resolve_valid_i)
      |=> ($stable(out_data_o) || resolve_valid_i));

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
  input  logic                  clk,
  input  logic                  rst,
  output fetch_pkg::addr_t      m_araddr_o,
  output logic                  m_arvalid_o,
  input  logic                  m_arready_i,
  input  fetch_pkg::inst_t      m_rdata_i,
  input  logic [1:0]            m_rresp_i,
  input  logic                  m_rvalid_i,
  output logic                  m_rready_o,
  output logic                  out_valid_o,
  output fetch_pkg::fetch_out_t out_data_o,
  input  logic                  out_ready_i,
  input  logic                  resolve_valid_i,
  input  fetch_pkg::resolve_t   resolve_i,
  output logic                  kill_o
);
  import fetch_pkg::*;

  addr_t lookup_pc;
  logic hit;
  inst_t inst;
  logic flush;

  logic req_valid;
  logic req_ready;
  refill_req_t req;
  logic rsp_valid;
  refill_rsp_t rsp;

  fetch_pc_ctrl u_pc_ctrl (
    .clk            (clk),
    .rst            (rst),
    .lookup_pc_o    (lookup_pc),
    .hit_i          (hit),
    .inst_i         (inst),
    .flush_o        (flush),
    .out_valid_o    (out_valid_o),
    .out_data_o     (out_data_o),
    .out_ready_i    (out_ready_i),
    .resolve_valid_i(resolve_valid_i),
    .resolve_i      (resolve_i),
    .kill_o         (kill_o)
  );

  fetch_icache u_icache (
    .clk        (clk),
    .rst        (rst),
    .lookup_pc_i(lookup_pc),
    .hit_o      (hit),
    .inst_o     (inst),
    .flush_i    (flush),
    .req_valid_o(req_valid),
    .req_o      (req),
    .req_ready_i(req_ready),
    .rsp_valid_i(rsp_valid),
    .rsp_i      (rsp)
  );

  fetch_axil_rd u_axil_rd (
    .clk        (clk),
    .rst        (rst),
    .req_valid_i(req_valid),
    .req_i      (req),
    .req_ready_o(req_ready),
    .rsp_valid_o(rsp_valid),
    .rsp_o      (rsp),
    .m_araddr_o (m_araddr_o),
    .m_arvalid_o(m_arvalid_o),
    .m_arready_i(m_arready_i),
    .m_rdata_i  (m_rdata_i),
    .m_rresp_i  (m_rresp_i),
    .m_rvalid_i (m_rvalid_i),
    .m_rready_o (m_rready_o)
  );

endmodule

// ==== test/tb_fetch_mem.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module tb_fetch_mem #(
  parameter int WORDS = 256
) (
  input  logic             clk,
  input  logic             rst,
  input  fetch_pkg::addr_t araddr_i,
  input  logic             arvalid_i,
  output logic             arready_o,
  output fetch_pkg::inst_t rdata_o,
  output logic [1:0]       rresp_o,
  output logic             rvalid_o,
  input  logic             rready_i,
  output int               read_count_o
);
  import fetch_pkg::*;

  // program image, loaded and rewritten by the testbench
  inst_t mem [WORDS];

  addr_t addr_q;
  logic busy_q;
  int lat_q;

  function automatic inst_t read_word(addr_t addr);
    addr_t offset;
    logic [11:0] imm;
    offset = addr - `FETCH_RESET_PC;
    if (offset < addr_t'(WORDS * 4)) begin
      return mem[int'(offset >> 2)];
    end
    // outside the image: an addi whose immediate mixes all address bits
    imm = addr[31:20] ^ addr[19:8] ^ {addr[7:2], 6'd0};
    return {imm, 5'd0, 3'b000, 5'd6, `FETCH_OP_ALU_IMM};
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      arready_o <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o <= '0;
      rresp_o <= 2'b00;
      busy_q <= 1'b0;
      lat_q <= 0;
      addr_q <= '0;
      read_count_o <= 0;
    end else if (!busy_q) begin
      if (arvalid_i && arready_o) begin
        busy_q <= 1'b1;
        addr_q <= araddr_i;
        lat_q <= int'($urandom_range(3, 0));
        arready_o <= 1'b0;
        read_count_o <= read_count_o + 1;
      end else begin
        arready_o <= ($urandom_range(1, 0) == 1);
      end
    end else if (!rvalid_o) begin
      // random read latency
      if (lat_q == 0) begin
        rvalid_o <= 1'b1;
        rdata_o <= read_word(addr_q);
      end else begin
        lat_q <= lat_q - 1;
      end
    end else if (rready_i) begin
      rvalid_o <= 1'b0;
      busy_q <= 1'b0;
    end
  end

endmodule

// ==== test/tb_fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int WORDS = 256;
  localparam int END_IDX = 20;
  localparam int END_REPEAT = 4;
  localparam int TIMEOUT = 20000;
  localparam int SETS = 1 << `FETCH_IDX_BITS;
  localparam int LINE_SHIFT = `FETCH_OFF_BITS + 2;

  logic clk;
  logic rst;
  addr_t m_araddr;
  logic m_arvalid;
  logic m_arready;
  inst_t m_rdata;
  logic [1:0] m_rresp;
  logic m_rvalid;
  logic m_rready;
  logic out_valid_o;
  fetch_out_t out_data_o;
  logic out_ready_i;
  logic resolve_valid_i;
  resolve_t resolve_i;
  logic kill_o;
  int read_count;

  inst_t prog [WORDS];
  int take_limit [WORDS];
  int res_cnt [WORDS];
  int gold_cnt [WORDS];
  fetch_out_t commit_q[$];
  fetch_out_t res_q[$];

  // reference cache of 4 sets with 2-word lines
  logic model_valid [SETS];
  addr_t model_line [SETS];
  int model_reads;

  addr_t gold_pc;
  int end_seen;
  int spec_commits;
  int res_age;
  int hold;
  int cycles;
  bit rewritten;
  bit done;

  fetch_top uut (
    .clk            (clk),
    .rst            (rst),
    .m_araddr_o     (m_araddr),
    .m_arvalid_o    (m_arvalid),
    .m_arready_i    (m_arready),
    .m_rdata_i      (m_rdata),
    .m_rresp_i      (m_rresp),
    .m_rvalid_i     (m_rvalid),
    .m_rready_o     (m_rready),
    .out_valid_o    (out_valid_o),
    .out_data_o     (out_data_o),
    .out_ready_i    (out_ready_i),
    .resolve_valid_i(resolve_valid_i),
    .resolve_i      (resolve_i),
    .kill_o         (kill_o)
  );

  tb_fetch_mem #(.WORDS(WORDS)) u_mem (
    .clk         (clk),
    .rst         (rst),
    .araddr_i    (m_araddr),
    .arvalid_i   (m_arvalid),
    .arready_o   (m_arready),
    .rdata_o     (m_rdata),
    .rresp_o     (m_rresp),
    .rvalid_o    (m_rvalid),
    .rready_i    (m_rready),
    .read_count_o(read_count)
  );

  always #50 clk = ~clk;

  // instruction encoders for the generated program
  function automatic inst_t enc_jal(int from_idx, int to_idx);
    logic [20:0] off;
    off = 21'((to_idx - from_idx) * 4);
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, `FETCH_OP_JAL};
  endfunction

  function automatic inst_t enc_bne(int from_idx, int to_idx);
    logic [12:0] off;
    off = 13'((to_idx - from_idx) * 4);
    return {off[12], off[10:5], 5'd2, 5'd1, 3'b001, off[4:1], off[11], `FETCH_OP_BRANCH};
  endfunction

  function automatic inst_t filler(int idx, int variant);
    logic [11:0] imm;
    imm = 12'(idx + variant * 256);
    return {imm, 5'd0, 3'b000, 5'd5, `FETCH_OP_ALU_IMM};
  endfunction

  function automatic inst_t enc_fencei();
    return {17'd0, `FETCH_OP_FENCEI_F3, 5'd0, `FETCH_OP_MISC_MEM};
  endfunction

  function automatic bit is_fencei(inst_t inst);
    return (inst[6:0] == `FETCH_OP_MISC_MEM) && (inst[14:12] == `FETCH_OP_FENCEI_F3);
  endfunction

  function automatic bit is_ctrl(inst_t inst);
    return (inst[6:0] == `FETCH_OP_JAL) || (inst[6:0] == `FETCH_OP_JALR) ||
           (inst[6:0] == `FETCH_OP_BRANCH) || (inst[6:0] == `FETCH_OP_SYSTEM) ||
           is_fencei(inst);
  endfunction

  function automatic int word_idx(addr_t addr);
    return int'((addr - `FETCH_RESET_PC) >> 2);
  endfunction

  // architectural next pc where taken decides conditional branches
  function automatic addr_t ref_next_pc(addr_t pc, inst_t inst, bit taken);
    addr_t imm;
    imm = addr_t'(4);
    if (inst[6:0] == `FETCH_OP_JAL) begin
      imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    end else if (inst[6:0] == `FETCH_OP_BRANCH && taken) begin
      imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    end
    return pc + imm;
  endfunction

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_fetch(fetch_out_t got, fetch_out_t exp);
    if (got.pc !== exp.pc || got.inst !== exp.inst) begin
      $display("Fail at %0d ns: committed pc %h inst %h, expected pc %h inst %h",
               $time, got.pc, got.inst, exp.pc, exp.inst);
      stop_run();
    end
  endtask

  task automatic check_count(int got, int exp);
    if (got != exp) begin
      $display("Fail at %0d ns: %0d bus reads, expected %0d", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < WORDS; i++) begin
      prog[i] = filler(i, 0);
      take_limit[i] = 0;
      res_cnt[i] = 0;
      gold_cnt[i] = 0;
    end
    // straight line, jump into a loop run twice, fence.i, then a jump back
    prog[6] = enc_jal(6, 10);
    prog[14] = enc_bne(14, 10);
    take_limit[14] = 1;
    prog[15] = enc_fencei();
    prog[16] = enc_jal(16, 10);
    // self loop ends the program
    prog[END_IDX] = enc_jal(END_IDX, END_IDX);
    for (int i = 0; i < WORDS; i++) begin
      u_mem.mem[i] = prog[i];
    end
  endtask

  // new loop body that leaves for the end loop
  task automatic rewrite_program();
    for (int i = 10; i < 14; i++) begin
      prog[i] = filler(i, 1);
      u_mem.mem[i] = prog[i];
    end
    prog[14] = enc_jal(14, END_IDX);
    u_mem.mem[14] = prog[14];
    rewritten = 1'b1;
  endtask

  task automatic model_lookup(addr_t pc);
    addr_t line;
    int set;
    line = pc >> LINE_SHIFT;
    set = int'(line % SETS);
    if (!model_valid[set] || model_line[set] != line) begin
      model_valid[set] = 1'b1;
      model_line[set] = line;
      model_reads += 1 << `FETCH_OFF_BITS;
    end
  endtask

  task automatic model_flush();
    for (int s = 0; s < SETS; s++) begin
      model_valid[s] = 1'b0;
    end
  endtask

  task automatic drop_spec();
    fetch_out_t keep_c[$];
    fetch_out_t keep_r[$];
    foreach (commit_q[i]) begin
      if (!commit_q[i].spec) keep_c.push_back(commit_q[i]);
    end
    foreach (res_q[i]) begin
      if (!res_q[i].spec) keep_r.push_back(res_q[i]);
    end
    commit_q = keep_c;
    res_q = keep_r;
  endtask

  // prediction held so the speculative items stand
  task automatic confirm_spec();
    fetch_out_t tmp;
    fetch_out_t keep_c[$];
    fetch_out_t keep_r[$];
    foreach (commit_q[i]) begin
      tmp = commit_q[i];
      if (tmp.spec) spec_commits++;
      tmp.spec = 1'b0;
      keep_c.push_back(tmp);
    end
    foreach (res_q[i]) begin
      tmp = res_q[i];
      tmp.spec = 1'b0;
      keep_r.push_back(tmp);
    end
    commit_q = keep_c;
    res_q = keep_r;
  endtask

  task automatic commit_item(fetch_out_t item);
    fetch_out_t exp;
    int idx;
    idx = word_idx(gold_pc);
    if (idx < 0 || idx >= WORDS) begin
      $display("golden path left the program at pc %h", gold_pc);
      stop_run();
    end
    exp = '{pc: gold_pc, inst: prog[idx], spec: 1'b0};
    check_fetch(item, exp);
    gold_pc = ref_next_pc(gold_pc, exp.inst, gold_cnt[idx] < take_limit[idx]);
    gold_cnt[idx]++;
    if (idx == END_IDX) begin
      end_seen++;
      if (end_seen >= END_REPEAT) done = 1'b1;
    end
  endtask

  // backend model
  always @(posedge clk) begin : backend
    fetch_out_t item;
    int idx;
    bit taken;
    if (rst) begin
      out_ready_i <= 1'b0;
      resolve_valid_i <= 1'b0;
      resolve_i <= '0;
    end else if (done) begin
      resolve_valid_i <= 1'b0;
    end else begin
      resolve_valid_i <= 1'b0;
      if (res_age < 3) res_age++;
      // kill_o answers the resolve of two edges ago
      if (res_age == 2) begin
        if (kill_o) begin
          if (end_seen > 0) begin
            $display("a kill hit the predicted end loop at %0d ns", $time);
            stop_run();
          end
          drop_spec();
        end else begin
          confirm_spec();
        end
      end else if (kill_o) begin
        $display("kill pulse without a preceding resolve at %0d ns", $time);
        stop_run();
      end
      while (commit_q.size() > 0 && !commit_q[0].spec) begin
        commit_item(commit_q.pop_front());
      end
      model_lookup(out_data_o.pc);
      if (out_valid_o && out_ready_i) begin
        item = out_data_o;
        commit_q.push_back(item);
        if (is_ctrl(item.inst)) res_q.push_back(item);
        if (is_fencei(item.inst)) begin
          model_flush();
          if (!rewritten) rewrite_program();
        end
      end
      if (res_age >= 2 && res_q.size() > 0) begin
        if (hold < 0) hold = int'($urandom_range(3, 0));
        if (hold == 0) begin
          item = res_q.pop_front();
          idx = word_idx(item.pc);
          taken = res_cnt[idx] < take_limit[idx];
          res_cnt[idx]++;
          resolve_i <= '{next_pc: ref_next_pc(item.pc, item.inst, taken),
                         fence: is_fencei(item.inst)};
          resolve_valid_i <= 1'b1;
          res_age = 0;
          hold = -1;
        end else begin
          hold--;
        end
      end
      out_ready_i <= ($urandom_range(3, 0) != 0);
    end
  end

  initial begin
    void'($urandom(13));
    clk = 1'b0;
    rst = 1'b1;
    out_ready_i = 1'b0;
    resolve_valid_i = 1'b0;
    resolve_i = '0;
    gold_pc = `FETCH_RESET_PC;
    end_seen = 0;
    spec_commits = 0;
    model_reads = 0;
    res_age = 3;
    hold = -1;
    rewritten = 1'b0;
    done = 1'b0;
    model_flush();
    load_program();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    while (!done && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      $display("timeout after %0d cycles, end loop reached %0d times", cycles, end_seen);
      stop_run();
    end else begin
      check_count(read_count, model_reads);
      if (spec_commits == 0) begin
        $display("no speculative item was ever confirmed");
        stop_run();
      end else begin
        $display("ALL CHECKS PASSED");
        $finish;
      end
    end
  end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_axil_rd.sv
verilog/fetch_icache.sv
verilog/fetch_pc_ctrl.sv
verilog/fetch_top.sv
test/tb_fetch_mem.sv
test/tb_fetch_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f build.f \
  --top-module tb_fetch_top \
  -o sim_fetch

# the simulator stops with an error status on failure, grep decides either way
./obj_dir/sim_fetch > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
